//--- eth_mac_tx.f
source/eth_tx_pkg.sv
source/tx_preamble_insert.sv
source/tx_fcs_append.sv
source/rgmii_tx.sv
source/eth_mac_tx.sv
tb/tb_eth_mac_tx.sv

//--- Makefile
# Verilator flow for the Ethernet MAC transmit path

VERILATOR   ?= verilator
TOP         ?= tb_eth_mac_tx
RTL_TOP     ?= eth_mac_tx
FILELIST    ?= eth_mac_tx.f
RTL_SRCS    ?= source/eth_tx_pkg.sv source/tx_preamble_insert.sv \
               source/tx_fcs_append.sv source/rgmii_tx.sv source/eth_mac_tx.sv
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing
PASS_STRING ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_STRING)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_eth_mac_tx.sv
`timescale 1ns/1ps

module tb_eth_mac_tx;

    localparam int PREAMBLE_LEN = 7;
    localparam int RISE_WAIT    = 100;   // Cycles allowed before a frame shows up
    localparam int FRAME_WAIT   = 2000;  // Cycles allowed for one frame

    logic       gmii_tx_clk;
    logic       tx_reset_sync;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic [7:0] gmii_txd;
    logic       rgmii_txc;
    logic       rgmii_tx_ctl;
    logic [3:0] rgmii_txd;

    logic [7:0] payload[$];    // Bytes of the frame being sent
    logic [7:0] exp_bytes[$];  // Preamble, SFD, payload and FCS
    logic [7:0] got_bytes[$];
    logic       got_ctl[$];    // Low-half control bit per byte

    eth_mac_tx #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) eth_mac_tx_inst (
        .gmii_tx_clk   (gmii_tx_clk),
        .tx_reset_sync (tx_reset_sync),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_tx_er    (gmii_tx_er),
        .gmii_txd      (gmii_txd),
        .rgmii_txc     (rgmii_txc),
        .rgmii_tx_ctl  (rgmii_tx_ctl),
        .rgmii_txd     (rgmii_txd)
    );

    initial begin
        gmii_tx_clk = 1'b0;
        forever #4 gmii_tx_clk = ~gmii_tx_clk;
    end

    // **************************************************************************
    // Checking and failure
    // **************************************************************************

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            end_with_failure();
        end
    endtask

    // Bit-serial CRC-32 over the payload, returned already complemented
    function automatic logic [31:0] payload_fcs();
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFF_FFFF;
        foreach (payload[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ payload[i][b];
                c  = c >> 1;
                if (fb) c = c ^ 32'hEDB8_8320;
            end
        end
        return ~c;
    endfunction

    function automatic void build_expected();
        logic [31:0] fcs;
        exp_bytes.delete();
        for (int i = 0; i < PREAMBLE_LEN; i++) exp_bytes.push_back(eth_tx_pkg::PREAMBLE_BYTE);
        exp_bytes.push_back(eth_tx_pkg::SFD_BYTE);
        foreach (payload[i]) exp_bytes.push_back(payload[i]);
        fcs = payload_fcs();
        for (int k = 0; k < eth_tx_pkg::FCS_LEN; k++) begin
            exp_bytes.push_back(fcs[8*k +: 8]);  // Low byte first
        end
    endfunction

    function automatic void fill_random(input int len);
        payload.delete();
        for (int i = 0; i < len; i++) payload.push_back(8'($urandom));
    endfunction

    // **************************************************************************
    // GMII driver and DDR sampler
    // **************************************************************************

    task automatic drive_frame(input int er_idx);
        foreach (payload[i]) begin
            @(posedge gmii_tx_clk);
            #1;
            gmii_tx_en = 1'b1;
            gmii_tx_er = (i == er_idx);
            gmii_txd   = payload[i];
        end
        @(posedge gmii_tx_clk);
        #1;
        gmii_tx_en = 1'b0;
        gmii_tx_er = 1'b0;
        gmii_txd   = 8'h00;
    endtask

    task automatic capture_frame();
        int         n;
        logic [3:0] lo;
        for (n = 0; n < RISE_WAIT; n++) begin
            @(posedge gmii_tx_clk);
            #2;  // Middle of the high half
            if (rgmii_tx_ctl) break;
        end
        if (!rgmii_tx_ctl) begin
            $display("Timeout waiting for rgmii_tx_ctl to rise");
            end_with_failure();
        end
        n = 0;
        while (rgmii_tx_ctl) begin
            lo = rgmii_txd;
            #4;  // Middle of the low half
            got_bytes.push_back({rgmii_txd, lo});
            got_ctl.push_back(rgmii_tx_ctl);
            @(posedge gmii_tx_clk);
            #2;
            n++;
            if (n > FRAME_WAIT) begin
                $display("Timeout waiting for the end of the RGMII frame");
                end_with_failure();
            end
        end
    endtask

    task automatic compare_frame(input int er_idx);
        eth_tx_pkg::fcs_state_t phase;
        int                     hdr_len;
        logic                   exp_ctl;
        hdr_len = PREAMBLE_LEN + 1;
        check_value("frame length", 32'(got_bytes.size()), 32'(exp_bytes.size()));
        for (int i = 0; i < exp_bytes.size(); i++) begin
            if (i < hdr_len) phase = eth_tx_pkg::FCS_IDLE;
            else if (i < hdr_len + payload.size()) phase = eth_tx_pkg::FCS_PASS;
            else phase = eth_tx_pkg::FCS_APPEND;
            exp_ctl = !(er_idx >= 0 && i == hdr_len + er_idx);  // Low only on the er byte
            check_value($sformatf("rgmii_txd byte %0d (%s)", i, phase.name()),
                        32'(got_bytes[i]), 32'(exp_bytes[i]));
            check_value($sformatf("rgmii_tx_ctl low half byte %0d (%s)", i, phase.name()),
                        32'(got_ctl[i]), 32'(exp_ctl));
        end
    endtask

    task automatic run_frame(input int er_idx);
        got_bytes.delete();
        got_ctl.delete();
        build_expected();
        fork
            drive_frame(er_idx);
            capture_frame();
        join
        compare_frame(er_idx);
        repeat (12) @(posedge gmii_tx_clk);  // Inter-frame idle
    endtask

    // **************************************************************************
    // Directed tests
    // **************************************************************************

    task automatic idle_after_reset();
        for (int i = 0; i < 20; i++) begin
            @(posedge gmii_tx_clk);
            #2;
            check_value("rgmii_txc high half", 32'(rgmii_txc), 32'h1);
            check_value("rgmii_tx_ctl high half", 32'(rgmii_tx_ctl), 32'h0);
            check_value("rgmii_txd high half", 32'(rgmii_txd), 32'h0);
            #4;
            check_value("rgmii_txc low half", 32'(rgmii_txc), 32'h0);
            check_value("rgmii_tx_ctl low half", 32'(rgmii_tx_ctl), 32'h0);
            check_value("rgmii_txd low half", 32'(rgmii_txd), 32'h0);
        end
    endtask

    task automatic incrementing_frame();
        payload.delete();
        for (int i = 0; i < 46; i++) payload.push_back(8'(i));
        run_frame(-1);
    endtask

    task automatic random_frames();
        for (int f = 0; f < 5; f++) begin
            fill_random(46 + int'($urandom % 55));
            run_frame(-1);
        end
    endtask

    task automatic error_byte_frame();
        fill_random(60);
        run_frame(17);  // er on payload byte 17
    endtask

    task automatic reset_mid_frame();
        fill_random(60);
        for (int i = 0; i < 20; i++) begin
            @(posedge gmii_tx_clk);
            #1;
            gmii_tx_en = 1'b1;
            gmii_txd   = payload[i];
        end
        @(posedge gmii_tx_clk);
        #1;
        tx_reset_sync = 1'b1;
        gmii_tx_en    = 1'b0;
        gmii_txd      = 8'h00;
        for (int i = 0; i < 4; i++) begin
            @(posedge gmii_tx_clk);
            #2;
            check_value("rgmii_tx_ctl high half in reset", 32'(rgmii_tx_ctl), 32'h0);
            #4;
            check_value("rgmii_tx_ctl low half in reset", 32'(rgmii_tx_ctl), 32'h0);
        end
        @(posedge gmii_tx_clk);
        #1;
        tx_reset_sync = 1'b0;
        // Nothing of the dropped frame may follow the reset
        for (int i = 0; i < 12; i++) begin
            @(posedge gmii_tx_clk);
            #2;
            check_value("rgmii_tx_ctl high half after reset", 32'(rgmii_tx_ctl), 32'h0);
            #4;
            check_value("rgmii_tx_ctl low half after reset", 32'(rgmii_tx_ctl), 32'h0);
        end
        fill_random(50);
        run_frame(-1);
    endtask

    initial begin
        void'($urandom(65534));
        tx_reset_sync = 1'b1;
        gmii_tx_en    = 1'b0;
        gmii_tx_er    = 1'b0;
        gmii_txd      = 8'h00;
        repeat (4) @(posedge gmii_tx_clk);
        #1;
        tx_reset_sync = 1'b0;

        idle_after_reset();
        incrementing_frame();
        random_frames();
        error_byte_frame();
        reset_mid_frame();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- source/eth_mac_tx.sv
`timescale 1ns/1ps

module eth_mac_tx #(
    parameter int PREAMBLE_LEN = 7  // Count of 0x55 bytes, 1 to 15
) (
    input  logic       gmii_tx_clk,
    input  logic       tx_reset_sync,
    input  logic       gmii_tx_en,
    input  logic       gmii_tx_er,
    input  logic [7:0] gmii_txd,
    output logic       rgmii_txc,
    output logic       rgmii_tx_ctl,
    output logic [3:0] rgmii_txd
);

    eth_tx_pkg::gmii_beat_t pre_beat;  // Framed, payload marked
    eth_tx_pkg::gmii_beat_t fcs_beat;  // With CRC trailer

    // **************************************************************************
    // Transmit pipeline
    // **************************************************************************

    // Preamble and SFD ahead of each frame
    tx_preamble_insert #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) tx_preamble_insert_inst (
        .gmii_tx_clk   (gmii_tx_clk),
        .tx_reset_sync (tx_reset_sync),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_tx_er    (gmii_tx_er),
        .gmii_txd      (gmii_txd),
        .pre_beat      (pre_beat)
    );

    // CRC-32 over the payload, FCS appended
    tx_fcs_append tx_fcs_append_inst (
        .gmii_tx_clk   (gmii_tx_clk),
        .tx_reset_sync (tx_reset_sync),
        .pre_beat      (pre_beat),
        .fcs_beat      (fcs_beat)
    );

    // Byte beats to DDR nibbles
    rgmii_tx rgmii_tx_inst (
        .gmii_tx_clk   (gmii_tx_clk),
        .tx_reset_sync (tx_reset_sync),
        .fcs_beat      (fcs_beat),
        .rgmii_txc     (rgmii_txc),
        .rgmii_tx_ctl  (rgmii_tx_ctl),
        .rgmii_txd     (rgmii_txd)
    );

endmodule

//--- source/rgmii_tx.sv
`timescale 1ns/1ps

module rgmii_tx (
    input  logic                   gmii_tx_clk,
    input  logic                   tx_reset_sync,
    input  eth_tx_pkg::gmii_beat_t fcs_beat,
    output logic                   rgmii_txc,
    output logic                   rgmii_tx_ctl,
    output logic [3:0]             rgmii_txd
);

    logic [7:0] txd_rise;
    logic       en_rise;
    logic       er_rise;
    logic [3:0] txd_fall;  // High nibble for the low half
    logic       ctl_fall;  // en XOR er for the low half

    // **************************************************************************
    // Rising edge register
    // **************************************************************************

    always_ff @(posedge gmii_tx_clk) begin
        if (tx_reset_sync) begin
            txd_rise <= 8'h00;
            en_rise  <= 1'b0;
            er_rise  <= 1'b0;
        end else begin
            txd_rise <= fcs_beat.data;
            en_rise  <= fcs_beat.en;
            er_rise  <= fcs_beat.er;
        end
    end

    // Second half of the same beat, taken half a cycle later
    always_ff @(negedge gmii_tx_clk) begin
        if (tx_reset_sync) begin
            txd_fall <= 4'h0;
            ctl_fall <= 1'b0;
        end else begin
            txd_fall <= txd_rise[7:4];
            ctl_fall <= en_rise ^ er_rise;
        end
    end

    // **************************************************************************
    // DDR output mux, clock level selects the half
    // **************************************************************************

    assign rgmii_txc    = gmii_tx_clk;  // No phase shift
    assign rgmii_txd    = gmii_tx_clk ? txd_rise[3:0] : txd_fall;
    assign rgmii_tx_ctl = gmii_tx_clk ? en_rise : ctl_fall;

endmodule

//--- source/tx_fcs_append.sv
`timescale 1ns/1ps

module tx_fcs_append (
    input  logic                   gmii_tx_clk,
    input  logic                   tx_reset_sync,
    input  eth_tx_pkg::gmii_beat_t pre_beat,
    output eth_tx_pkg::gmii_beat_t fcs_beat
);

    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // Reflected 802.3 polynomial
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    eth_tx_pkg::fcs_state_t state;
    logic [31:0]            crc;
    logic [31:0]            fcs;
    logic [1:0]             fcs_cnt;  // Trailer byte being sent
    eth_tx_pkg::gmii_beat_t fcs_out;

    // One byte through the reflected CRC-32, LSB first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc_in,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc_in ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign fcs = ~crc;

    // Trailer beat, low byte of the complemented CRC first
    always_comb begin
        fcs_out      = '0;
        fcs_out.data = fcs[8*fcs_cnt +: 8];
        fcs_out.en   = 1'b1;
    end

    // **************************************************************************
    // FCS FSM
    // **************************************************************************

    always_ff @(posedge gmii_tx_clk) begin
        if (tx_reset_sync) begin
            state    <= eth_tx_pkg::FCS_IDLE;
            crc      <= CRC_INIT;
            fcs_cnt  <= 2'd0;
            fcs_beat <= '0;
        end else begin
            case (state)
                eth_tx_pkg::FCS_IDLE: begin
                    fcs_beat <= pre_beat;  // Preamble, SFD and idle pass untouched
                    if (pre_beat.payload) begin
                        crc   <= crc32_byte(CRC_INIT, pre_beat.data);
                        state <= eth_tx_pkg::FCS_PASS;
                    end else begin
                        crc <= CRC_INIT;
                    end
                end

                eth_tx_pkg::FCS_PASS: begin
                    if (pre_beat.payload) begin
                        fcs_beat <= pre_beat;
                        crc      <= crc32_byte(crc, pre_beat.data);  // er bytes count too
                    end else begin
                        // End of payload, the idle beat becomes FCS byte 0
                        fcs_beat <= fcs_out;
                        fcs_cnt  <= 2'd1;
                        state    <= eth_tx_pkg::FCS_APPEND;
                    end
                end

                eth_tx_pkg::FCS_APPEND: begin
                    fcs_beat <= fcs_out;  // Incoming idle beats are dropped here
                    fcs_cnt  <= fcs_cnt + 2'd1;
                    if (fcs_cnt == 2'(eth_tx_pkg::FCS_LEN - 1)) begin
                        state <= eth_tx_pkg::FCS_IDLE;
                    end
                end

                default: begin
                    state <= eth_tx_pkg::FCS_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/tx_preamble_insert.sv
`timescale 1ns/1ps

module tx_preamble_insert #(
    parameter int PREAMBLE_LEN = 7
) (
    input  logic                   gmii_tx_clk,
    input  logic                   tx_reset_sync,
    input  logic                   gmii_tx_en,
    input  logic                   gmii_tx_er,
    input  logic [7:0]             gmii_txd,
    output eth_tx_pkg::gmii_beat_t pre_beat
);

    localparam int CNT_W = $clog2(PREAMBLE_LEN + 1);

    eth_tx_pkg::gmii_beat_t in_beat;
    eth_tx_pkg::gmii_beat_t dly [PREAMBLE_LEN+1];  // Holds the frame while the header goes out
    eth_tx_pkg::gmii_beat_t hdr_beat;
    logic [CNT_W-1:0]       hdr_cnt;
    logic                   hdr_last;
    logic                   frame_start;

    // Idle cycles carry zero data
    always_comb begin
        in_beat.data    = (gmii_tx_en || gmii_tx_er) ? gmii_txd : 8'h00;
        in_beat.en      = gmii_tx_en;
        in_beat.er      = gmii_tx_er;
        in_beat.payload = gmii_tx_en;
    end

    assign frame_start = gmii_tx_en && !dly[0].en;  // Rising edge of en
    assign hdr_last    = (hdr_cnt == CNT_W'(PREAMBLE_LEN));

    // Preamble bytes, then the SFD on the last header count
    always_comb begin
        hdr_beat      = '0;
        hdr_beat.data = hdr_last ? eth_tx_pkg::SFD_BYTE : eth_tx_pkg::PREAMBLE_BYTE;
        hdr_beat.en   = 1'b1;
    end

    // **************************************************************************
    // Delay line, PREAMBLE_LEN+1 beats deep
    // **************************************************************************

    always_ff @(posedge gmii_tx_clk) begin
        if (tx_reset_sync) begin
            for (int i = 0; i <= PREAMBLE_LEN; i++) begin
                dly[i] <= '0;
            end
        end else begin
            dly[0] <= in_beat;
            for (int i = 1; i <= PREAMBLE_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    // **************************************************************************
    // Header counter and output register
    // **************************************************************************

    always_ff @(posedge gmii_tx_clk) begin
        if (tx_reset_sync) begin
            hdr_cnt  <= '0;
            pre_beat <= '0;
        end else if (frame_start || hdr_cnt != '0) begin
            pre_beat <= hdr_beat;
            hdr_cnt  <= hdr_last ? '0 : hdr_cnt + 1'b1;  // Count 0 only on frame_start
        end else begin
            pre_beat <= dly[PREAMBLE_LEN];  // First payload byte lands right after the SFD
        end
    end

endmodule

//--- source/eth_tx_pkg.sv
package eth_tx_pkg;

    // **************************************************************************
    // Framing constants
    // **************************************************************************

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;  // Repeated ahead of the SFD
    localparam logic [7:0] SFD_BYTE      = 8'hD5;  // Start of frame delimiter
    localparam int         FCS_LEN       = 4;      // CRC-32 trailer bytes

    // **************************************************************************
    // Stream beat
    // **************************************************************************

    // One gmii_tx_clk cycle of the transmit stream, passed stage to stage
    typedef struct packed {
        logic [7:0] data;
        logic       en;
        logic       er;
        logic       payload;  // Byte goes into the CRC
    } gmii_beat_t;

    // **************************************************************************
    // FCS stage
    // **************************************************************************

    // IDLE waits for payload, PASS runs the CRC, APPEND sends the trailer
    typedef enum logic [1:0] {
        FCS_IDLE   = 2'd0,
        FCS_PASS   = 2'd1,
        FCS_APPEND = 2'd2
    } fcs_state_t;

endpackage
